/* common/core_ctrl_pkg.sv */
// -------------------------------------------------
// Core control package
// Widths, CLINT register map, reset values and AXI response codes
// -------------------------------------------------
package core_ctrl_pkg;

   // -------------------------------------------------
   // Widths with a meaning
   // -------------------------------------------------
   typedef logic [31:0] reg_t;                        // Register or data word
   typedef logic [63:0] dword_t;                      // mtime and mtimecmp
   typedef logic [31:0] pc_t;                         // Program counter address
   typedef logic [15:0] mmr_addr_t;                   // Offset inside the CLINT window
   typedef logic [3:0]  strb_t;                       // Byte lane enables

   // -------------------------------------------------
   // CLINT register map
   // -------------------------------------------------
   // Software interrupt pending, only bit 0 is real
   localparam mmr_addr_t MSIP_OFS        = 16'h0000;

   // Timer compare, two 32 bit halves
   localparam mmr_addr_t MTIMECMP_LO_OFS = 16'h4000;
   localparam mmr_addr_t MTIMECMP_HI_OFS = 16'h4004;

   // Free running timer, two 32 bit halves
   localparam mmr_addr_t MTIME_LO_OFS    = 16'hBFF8;
   localparam mmr_addr_t MTIME_HI_OFS    = 16'hBFFC;

   // -------------------------------------------------
   // Reset values
   // -------------------------------------------------
   // All ones keeps the timer interrupt quiet after reset
   localparam dword_t    MTIMECMP_RST    = 64'hFFFF_FFFF_FFFF_FFFF;

   // -------------------------------------------------
   // AXI responses
   // -------------------------------------------------
   localparam logic [1:0] RESP_OKAY      = 2'b00;    // Mapped offset
   localparam logic [1:0] RESP_SLVERR    = 2'b10;    // Unmapped offset

endpackage

/* clint/clint_axi_port.sv */
`timescale 1ns/100ps
// -------------------------------------------------
// CLINT AXI4-Lite slave port
// Channel handshakes, offset decode into write selects, registered read mux
// -------------------------------------------------
module clint_axi_port
(
   input  logic                     clk_in,
   input  logic                     arst_n,

   // Write address and data channels
   input  logic                     awvalid,
   output logic                     awready,
   input  core_ctrl_pkg::mmr_addr_t awaddr,
   input  logic                     wvalid,
   output logic                     wready,
   input  core_ctrl_pkg::reg_t      wdata,
   input  core_ctrl_pkg::strb_t     wstrb,

   // Write response channel
   output logic                     bvalid,
   input  logic                     bready,
   output logic [1:0]               bresp,

   // Read address and data channels
   input  logic                     arvalid,
   output logic                     arready,
   input  core_ctrl_pkg::mmr_addr_t araddr,
   output logic                     rvalid,
   input  logic                     rready,
   output core_ctrl_pkg::reg_t      rdata,
   output logic [1:0]               rresp,

   // Write selects towards the timer block
   output logic                     sel_msip,
   output logic                     sel_cmp_lo,
   output logic                     sel_cmp_hi,
   output logic                     sel_time_lo,
   output logic                     sel_time_hi,
   output core_ctrl_pkg::reg_t      wr_data,
   output core_ctrl_pkg::strb_t     wr_strb,

   // Register contents for reads
   input  core_ctrl_pkg::reg_t      msip_reg,
   input  core_ctrl_pkg::dword_t    mtime,
   input  core_ctrl_pkg::dword_t    mtimecmp
);
   import core_ctrl_pkg::*;

   typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
   typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

   wr_state_t wr_state;
   rd_state_t rd_state;
   logic      wr_go;                                  // AW and W accepted this cycle
   logic      rd_go;                                  // AR accepted this cycle
   logic      wr_hit;                                 // Write offset is mapped
   logic      rd_hit;                                 // Read offset is mapped
   reg_t      rd_mux;                                 // Read data before capture

   // -------------------------------------------------
   // Write channel
   // -------------------------------------------------
   // Both channels taken together, never while a response waits
   assign wr_go   = awvalid & wvalid & (wr_state == WR_IDLE);
   assign awready = wr_go;
   assign wready  = wr_go;
   assign bvalid  = (wr_state == WR_RESP);

   assign wr_data = wdata;                            // Merged by lane in the timer
   assign wr_strb = wstrb;

   always_comb
   begin
      wr_hit      = 1'b1;
      sel_msip    = 1'b0;
      sel_cmp_lo  = 1'b0;
      sel_cmp_hi  = 1'b0;
      sel_time_lo = 1'b0;
      sel_time_hi = 1'b0;
      case (awaddr)
         MSIP_OFS:        sel_msip    = wr_go;
         MTIMECMP_LO_OFS: sel_cmp_lo  = wr_go;
         MTIMECMP_HI_OFS: sel_cmp_hi  = wr_go;
         MTIME_LO_OFS:    sel_time_lo = wr_go;
         MTIME_HI_OFS:    sel_time_hi = wr_go;
         default:         wr_hit      = 1'b0;         // Dropped, SLVERR below
      endcase
   end

   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         wr_state <= WR_IDLE;
      else
      begin
         case (wr_state)
            WR_IDLE:
               if (wr_go)
                  wr_state <= WR_RESP;
            WR_RESP:
               if (bready)
                  wr_state <= WR_IDLE;
            default:
               wr_state <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_in)
   begin
      if (wr_go)
         bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;   // Held until bready
   end

   // -------------------------------------------------
   // Read channel
   // -------------------------------------------------
   assign arready = (rd_state == RD_IDLE);
   assign rd_go   = arvalid & arready;
   assign rvalid  = (rd_state == RD_RESP);

   always_comb
   begin
      rd_hit = 1'b1;
      case (araddr)
         MSIP_OFS:        rd_mux = msip_reg;
         MTIMECMP_LO_OFS: rd_mux = mtimecmp[31:0];
         MTIMECMP_HI_OFS: rd_mux = mtimecmp[63:32];
         MTIME_LO_OFS:    rd_mux = mtime[31:0];
         MTIME_HI_OFS:    rd_mux = mtime[63:32];
         default:
         begin
            rd_mux = '0;                              // Unmapped reads as zero
            rd_hit = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         rd_state <= RD_IDLE;
      else
      begin
         case (rd_state)
            RD_IDLE:
               if (rd_go)
                  rd_state <= RD_RESP;
            RD_RESP:
               if (rready)
                  rd_state <= RD_IDLE;
            default:
               rd_state <= RD_IDLE;
         endcase
      end
   end

   // mtime is sampled on the AR handshake edge
   always_ff @(posedge clk_in)
   begin
      if (rd_go)
      begin
         rdata <= rd_mux;
         rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      end
   end

   // -------------------------------------------------
   // Checks
   // -------------------------------------------------
   // Stalled responses keep their payload
   a_resp_stable: assert property (@(posedge clk_in) disable iff (!arst_n)
      ((bvalid && !bready) |=> $stable(bresp)) and
      ((rvalid && !rready) |=> ($stable(rdata) && $stable(rresp))));

   // Timer sees at most one register written per cycle
   a_sel_onehot: assert property (@(posedge clk_in) disable iff (!arst_n)
      $onehot0({sel_msip, sel_cmp_lo, sel_cmp_hi, sel_time_lo, sel_time_hi}));

endmodule

/* clint/clint_timer.sv */
`timescale 1ns/100ps
// -------------------------------------------------
// CLINT timer registers
// msip, mtime and mtimecmp with byte lane writes and interrupt outputs
// -------------------------------------------------
module clint_timer
(
   input  logic                  clk_in,
   input  logic                  arst_n,

   // Write selects from the AXI port
   input  logic                  sel_msip,
   input  logic                  sel_cmp_lo,
   input  logic                  sel_cmp_hi,
   input  logic                  sel_time_lo,
   input  logic                  sel_time_hi,
   input  core_ctrl_pkg::reg_t   wr_data,
   input  core_ctrl_pkg::strb_t  wr_strb,

   // Register contents
   output core_ctrl_pkg::reg_t   msip_reg,
   output core_ctrl_pkg::dword_t mtime,
   output core_ctrl_pkg::dword_t mtimecmp,

   // Interrupts
   output logic                  timer_irq,
   output logic                  sw_irq
);
   import core_ctrl_pkg::*;

   logic msip_bit;                                    // Only writable msip bit
   logic any_wr;                                      // mtime or mtimecmp touched

   // Replace the lanes whose strobe is set, keep the rest
   function automatic reg_t lane_merge(input reg_t cur, input reg_t wd, input strb_t strb);
      reg_t res;
      res = cur;
      for (int i = 0; i < 4; i++)
      begin
         if (strb[i])
            res[8*i +: 8] = wd[8*i +: 8];
      end
      return res;
   endfunction

   // -------------------------------------------------
   // Registers
   // -------------------------------------------------
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         msip_bit <= 1'b0;
      else if (sel_msip && wr_strb[0])
         msip_bit <= wr_data[0];
   end

   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         mtimecmp <= MTIMECMP_RST;
      else if (sel_cmp_lo)
         mtimecmp[31:0]  <= lane_merge(mtimecmp[31:0], wr_data, wr_strb);
      else if (sel_cmp_hi)
         mtimecmp[63:32] <= lane_merge(mtimecmp[63:32], wr_data, wr_strb);
   end

   // Free running, a write loads instead of counting
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         mtime <= '0;
      else if (sel_time_lo)
         mtime <= {mtime[63:32], lane_merge(mtime[31:0], wr_data, wr_strb)};
      else if (sel_time_hi)
         mtime <= {lane_merge(mtime[63:32], wr_data, wr_strb), mtime[31:0]};
      else
         mtime <= mtime + 64'd1;                      // Carry into hi half
   end

   assign msip_reg = {31'd0, msip_bit};               // Upper bits read as zero

   // -------------------------------------------------
   // Interrupts
   // -------------------------------------------------
   assign timer_irq = (mtime >= mtimecmp);            // Pending at or past compare
   assign sw_irq    = msip_bit;

   assign any_wr = sel_cmp_lo | sel_cmp_hi | sel_time_lo | sel_time_hi;

   // Without a write, the next compare follows from the counted mtime
   a_timer_irq: assert property (@(posedge clk_in) disable iff (!arst_n)
      !any_wr |=> (timer_irq == (($past(mtime) + 64'd1) >= $past(mtimecmp))));

endmodule

/* rtl/pipe_control.sv */
`timescale 1ns/100ps
// -------------------------------------------------
// Pipeline control
// WFI halt and wake, flush and PC reload steering
// -------------------------------------------------
module pipe_control
(
   input  logic               clk_in,
   input  logic               arst_n,

   // Interrupt sources and sleep request
   input  logic               ext_irq,
   input  logic               timer_irq,
   input  logic               sw_irq,
   input  logic               wfi_req,

   // Reload requests from write-back and execute
   input  logic               wb_reload,
   input  logic               wb_ic_reload,
   input  core_ctrl_pkg::pc_t wb_reload_addr,
   input  logic               exe_reload,
   input  core_ctrl_pkg::pc_t exe_reload_addr,

   // Halt, flush and reload outputs
   output logic               cpu_halt,
   output logic               flush_dec,
   output logic               flush_exe,
   output logic               flush_mem,
   output logic               pc_reload,
   output logic               ic_reload,
   output core_ctrl_pkg::pc_t pc_reload_addr
);

   typedef enum logic {RUN, SLEEP} halt_state_t;

   halt_state_t halt_state;
   logic        irq_any;                              // Any wake source

   // -------------------------------------------------
   // Halt FSM
   // -------------------------------------------------
   assign irq_any = ext_irq | timer_irq | sw_irq;

   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         halt_state <= RUN;
      else
      begin
         case (halt_state)
            RUN:
               if (wfi_req && !irq_any)               // Pending interrupt beats WFI
                  halt_state <= SLEEP;
            SLEEP:
               if (irq_any)
                  halt_state <= RUN;
            default:
               halt_state <= RUN;
         endcase
      end
   end

   assign cpu_halt = (halt_state == SLEEP);

   // -------------------------------------------------
   // Reload steering
   // -------------------------------------------------
   // A branch miss from execute leaves the memory stage alone
   assign flush_dec = wb_reload | exe_reload;
   assign flush_exe = wb_reload | exe_reload;
   assign flush_mem = wb_reload;

   assign pc_reload = wb_reload | exe_reload;
   assign ic_reload = wb_ic_reload;                   // Store hit the I$ range

   // Write-back is older, so it wins
   assign pc_reload_addr = wb_reload ? wb_reload_addr : exe_reload_addr;

   // Reload targets come from the stages and must be word aligned
   a_rld_align: assert property (@(posedge clk_in) disable iff (!arst_n)
      pc_reload |-> (pc_reload_addr[1:0] == 2'b00));

endmodule

/* rtl/core_ctrl_top.sv */
`timescale 1ns/100ps
// -------------------------------------------------
// Core control top
// CLINT behind AXI4-Lite plus halt and reload steering
// -------------------------------------------------
module core_ctrl_top
(
   input  logic                     clk_in,
   input  logic                     arst_n,

   // AXI4-Lite slave
   input  logic                     awvalid,
   output logic                     awready,
   input  core_ctrl_pkg::mmr_addr_t awaddr,
   input  logic                     wvalid,
   output logic                     wready,
   input  core_ctrl_pkg::reg_t      wdata,
   input  core_ctrl_pkg::strb_t     wstrb,
   output logic                     bvalid,
   input  logic                     bready,
   output logic [1:0]               bresp,
   input  logic                     arvalid,
   output logic                     arready,
   input  core_ctrl_pkg::mmr_addr_t araddr,
   output logic                     rvalid,
   input  logic                     rready,
   output core_ctrl_pkg::reg_t      rdata,
   output logic [1:0]               rresp,

   // Interrupts and sleep
   input  logic                     ext_irq,
   input  logic                     wfi_req,
   output logic                     timer_irq,
   output logic                     sw_irq,
   output logic                     cpu_halt,

   // Stage reload requests and steering
   input  logic                     wb_reload,
   input  logic                     wb_ic_reload,
   input  core_ctrl_pkg::pc_t       wb_reload_addr,
   input  logic                     exe_reload,
   input  core_ctrl_pkg::pc_t       exe_reload_addr,
   output logic                     flush_dec,
   output logic                     flush_exe,
   output logic                     flush_mem,
   output logic                     pc_reload,
   output logic                     ic_reload,
   output core_ctrl_pkg::pc_t       pc_reload_addr
);
   import core_ctrl_pkg::*;

   logic   sel_msip, sel_cmp_lo, sel_cmp_hi;          // One cycle write selects
   logic   sel_time_lo, sel_time_hi;
   reg_t   wr_data;
   strb_t  wr_strb;
   reg_t   msip_reg;
   dword_t mtime;
   dword_t mtimecmp;

   clint_axi_port u_axi_port
   (
      .clk_in(clk_in), .arst_n(arst_n),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
      .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
      .bvalid(bvalid), .bready(bready), .bresp(bresp),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
      .sel_msip(sel_msip), .sel_cmp_lo(sel_cmp_lo), .sel_cmp_hi(sel_cmp_hi),
      .sel_time_lo(sel_time_lo), .sel_time_hi(sel_time_hi),
      .wr_data(wr_data), .wr_strb(wr_strb),
      .msip_reg(msip_reg), .mtime(mtime), .mtimecmp(mtimecmp)
   );

   clint_timer u_timer
   (
      .clk_in(clk_in), .arst_n(arst_n),
      .sel_msip(sel_msip), .sel_cmp_lo(sel_cmp_lo), .sel_cmp_hi(sel_cmp_hi),
      .sel_time_lo(sel_time_lo), .sel_time_hi(sel_time_hi),
      .wr_data(wr_data), .wr_strb(wr_strb),
      .msip_reg(msip_reg), .mtime(mtime), .mtimecmp(mtimecmp),
      .timer_irq(timer_irq), .sw_irq(sw_irq)
   );

   pipe_control u_pipe_ctrl
   (
      .clk_in(clk_in), .arst_n(arst_n),
      .ext_irq(ext_irq), .timer_irq(timer_irq), .sw_irq(sw_irq), .wfi_req(wfi_req),
      .wb_reload(wb_reload), .wb_ic_reload(wb_ic_reload), .wb_reload_addr(wb_reload_addr),
      .exe_reload(exe_reload), .exe_reload_addr(exe_reload_addr),
      .cpu_halt(cpu_halt),
      .flush_dec(flush_dec), .flush_exe(flush_exe), .flush_mem(flush_mem),
      .pc_reload(pc_reload), .ic_reload(ic_reload), .pc_reload_addr(pc_reload_addr)
   );

endmodule

/* tests/tb_core_ctrl_ref.svh */
// -------------------------------------------------
// Reference model for the core control testbench
// Register merging, read decode, interrupt rules, reload steering
// -------------------------------------------------
`ifndef TB_CORE_CTRL_REF_SVH
`define TB_CORE_CTRL_REF_SVH

// Strobed lanes take the new byte, others keep the old one
function automatic logic [31:0] merge_lanes(input logic [31:0] cur, input logic [31:0] wd,
                                            input logic [3:0] strb);
   logic [31:0] res;
   res = cur;
   for (int i = 0; i < 4; i++)
   begin
      if (strb[i])
         res[8*i +: 8] = wd[8*i +: 8];
   end
   return res;
endfunction

// msip holds a single bit in lane 0
function automatic logic [31:0] merge_msip(input logic [31:0] cur, input logic [31:0] wd,
                                           input logic [3:0] strb);
   if (strb[0])
      return {31'd0, wd[0]};
   return cur;
endfunction

function automatic logic offset_mapped(input logic [15:0] ofs);
   return (ofs == OFS_MSIP) || (ofs == OFS_CMP_LO) || (ofs == OFS_CMP_HI) ||
          (ofs == OFS_TIME_LO) || (ofs == OFS_TIME_HI);
endfunction

function automatic logic [31:0] expect_rdata(input logic [15:0] ofs, input logic [31:0] msip,
                                             input logic [63:0] cmp, input logic [63:0] mtime);
   case (ofs)
      OFS_MSIP:    return msip;
      OFS_CMP_LO:  return cmp[31:0];
      OFS_CMP_HI:  return cmp[63:32];
      OFS_TIME_LO: return mtime[31:0];
      OFS_TIME_HI: return mtime[63:32];
      default:     return 32'd0;                      // Unmapped reads as zero
   endcase
endfunction

function automatic logic [1:0] expect_resp(input logic [15:0] ofs);
   return offset_mapped(ofs) ? RSP_OKAY : RSP_SLVERR;
endfunction

// Read of mtime n edges after loading v, at least one count later
function automatic logic mtime_in_window(input logic [63:0] v, input logic [63:0] n,
                                         input logic [31:0] data, input logic hi_half);
   logic [63:0] lo_bound;
   logic [63:0] hi_bound;
   logic [31:0] delta;
   lo_bound = v + 64'd1;
   hi_bound = v + n;
   delta    = data - v[31:0];                         // Wraps like the counter
   if (hi_half)
      return (data >= lo_bound[63:32]) && (data <= hi_bound[63:32]);
   return (delta >= 32'd1) && (delta <= n[31:0]);
endfunction

function automatic logic timer_pending(input logic [63:0] mtime, input logic [63:0] cmp);
   return mtime >= cmp;
endfunction

// Any interrupt wins over WFI
function automatic logic halt_next(input logic halt, input logic wfi, input logic ext,
                                   input logic tmr, input logic sw);
   if (ext || tmr || sw)
      return 1'b0;
   if (wfi)
      return 1'b1;
   return halt;
endfunction

// {flush_dec, flush_exe, flush_mem, pc_reload, ic_reload, pc_reload_addr}
function automatic logic [36:0] steer_ref(input logic wb, input logic wb_ic,
                                          input logic [31:0] wb_addr, input logic exe,
                                          input logic [31:0] exe_addr);
   logic any_rld;
   any_rld = wb | exe;
   return {any_rld, any_rld, wb, any_rld, wb_ic, (wb ? wb_addr : exe_addr)};
endfunction

`endif

/* tests/tb_core_ctrl.sv */
`timescale 1ns/100ps
// -------------------------------------------------
// Core control testbench
// CLINT over AXI4-Lite, halt and wake, reload steering
// -------------------------------------------------
module tb_core_ctrl;

   // CLINT map as seen from the bus
   localparam logic [15:0] OFS_MSIP    = 16'h0000;
   localparam logic [15:0] OFS_CMP_LO  = 16'h4000;
   localparam logic [15:0] OFS_CMP_HI  = 16'h4004;
   localparam logic [15:0] OFS_TIME_LO = 16'hBFF8;
   localparam logic [15:0] OFS_TIME_HI = 16'hBFFC;
   localparam logic [1:0]  RSP_OKAY    = 2'b00;
   localparam logic [1:0]  RSP_SLVERR  = 2'b10;
   localparam int          TMR_GAP     = 30;         // mtimecmp above a fresh mtime
   localparam int          N_TRANS     = 4 + 99 + 10 + 8 + 8 + 1;  // Steering run counts once

   `include "tb_core_ctrl_ref.svh"

   logic        clk_in;
   logic        arst_n;
   logic        awvalid, awready, wvalid, wready, bvalid, bready;
   logic        arvalid, arready, rvalid, rready;
   logic [15:0] awaddr, araddr;
   logic [31:0] wdata, rdata;
   logic [3:0]  wstrb;
   logic [1:0]  bresp, rresp;
   logic        ext_irq, wfi_req, timer_irq, sw_irq, cpu_halt;
   logic        wb_reload, wb_ic_reload, exe_reload;
   logic [31:0] wb_reload_addr, exe_reload_addr, pc_reload_addr;
   logic        flush_dec, flush_exe, flush_mem, pc_reload, ic_reload;

   int          err_cnt = 0;
   int          chk_cnt = 0;
   int          cyc     = 0;                          // Rising edges so far
   int          last_hs;                              // Edge of the last handshake
   int          t_wr;
   integer      seed;
   logic [31:0] rnd, rd, data, w_hi, w_lo;
   logic [15:0] addr;
   logic [31:0] msip_sh;                              // Shadow registers
   logic [63:0] cmp_sh;
   logic        exp_halt;
   logic        tmr_pend;                             // Timer interrupt the stimulus set up
   logic        sw_pend;                              // msip bit 0 as last written
   logic [36:0] steer_exp;

   core_ctrl_top dut0 (.*);

   always #20 clk_in = ~clk_in;                       // 40 ns period

   always @(posedge clk_in)
      cyc <= cyc + 1;

   // -------------------------------------------------
   // Check and bus tasks
   // -------------------------------------------------
   task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
      chk_cnt++;
      assert (got === exp)
      else
      begin
         err_cnt++;
         $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
      end
   endtask

   // Write, wait for bvalid, check bresp
   task automatic axi_write(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s,
                            input logic [1:0] exp_resp);
      @(negedge clk_in);
      awaddr  = a;
      wdata   = d;
      wstrb   = s;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge clk_in);
      while (!bvalid)
         @(negedge clk_in);
      // Valids still high here, a pending response must hold off the next write
      check_eq({awready, wready}, 2'b00, "awready and wready while bvalid is high");
      awvalid = 1'b0;
      wvalid  = 1'b0;
      last_hs = cyc;                                  // Handshake was the latest edge
      check_eq(bresp, exp_resp, $sformatf("bresp at %h", a));
   endtask

   task automatic axi_read(input logic [15:0] a, output logic [31:0] d,
                           input logic [1:0] exp_resp);
      @(negedge clk_in);
      araddr  = a;
      arvalid = 1'b1;
      @(negedge clk_in);
      while (!rvalid)
         @(negedge clk_in);
      check_eq(arready, 1'b0, "arready while rvalid is high");
      arvalid = 1'b0;
      last_hs = cyc;
      d       = rdata;
      check_eq(rresp, exp_resp, $sformatf("rresp at %h", a));
   endtask

   // Drive one cycle of WFI and ext_irq, predict cpu_halt
   task automatic step_halt(input logic wfi, input logic ext);
      @(negedge clk_in);
      check_eq(cpu_halt, exp_halt, "cpu_halt");
      wfi_req  = wfi;
      ext_irq  = ext;
      exp_halt = halt_next(exp_halt, wfi, ext, tmr_pend, sw_pend);
   endtask

   // A register write raises an interrupt, the hart wakes one cycle later
   task automatic wake_by_write(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s);
      axi_write(a, d, s, RSP_OKAY);
      check_eq(cpu_halt, exp_halt, "cpu_halt on interrupt edge");
      exp_halt = halt_next(exp_halt, 1'b0, 1'b0, tmr_pend, sw_pend);
      step_halt(1'b0, 1'b0);
   endtask

   // -------------------------------------------------
   // Steering comparison, outputs settled since the falling edge
   // -------------------------------------------------
   always @(posedge clk_in)
   begin
      if (arst_n)
      begin
         steer_exp = steer_ref(wb_reload, wb_ic_reload, wb_reload_addr, exe_reload,
                               exe_reload_addr);
         check_eq({flush_dec, flush_exe, flush_mem, pc_reload, ic_reload, pc_reload_addr},
                  steer_exp, "reload steering");
      end
   end

   // Watchdog
   initial
   begin
      repeat (N_TRANS * 200) @(posedge clk_in);
      $display("TIMEOUT: no response after %0d cycles, a handshake never completed",
               N_TRANS * 200);
      $display("*** FAILED ***");
      $finish;
   end

   // -------------------------------------------------
   // Stimulus
   // -------------------------------------------------
   initial
   begin
      seed            = 50;
      clk_in          = 1'b0;
      arst_n          = 1'b0;
      awvalid         = 1'b0;
      awaddr          = '0;
      wvalid          = 1'b0;
      wdata           = '0;
      wstrb           = '0;
      bready          = 1'b1;                         // Responses always taken
      arvalid         = 1'b0;
      araddr          = '0;
      rready          = 1'b1;
      ext_irq         = 1'b0;
      wfi_req         = 1'b0;
      wb_reload       = 1'b0;
      wb_ic_reload    = 1'b0;
      wb_reload_addr  = '0;
      exe_reload      = 1'b0;
      exe_reload_addr = '0;
      msip_sh         = 32'd0;
      cmp_sh          = 64'hFFFF_FFFF_FFFF_FFFF;
      repeat (4) @(negedge clk_in);
      arst_n = 1'b1;

      // 1. Reset state
      @(negedge clk_in);
      check_eq({cpu_halt, timer_irq, sw_irq}, 3'b000, "halt and interrupts after reset");
      check_eq({awready, wready, bvalid, rvalid, arready}, 5'b00001,
               "AXI handshake outputs after reset");
      axi_read(OFS_MSIP, rd, RSP_OKAY);
      check_eq(rd, expect_rdata(OFS_MSIP, msip_sh, cmp_sh, 64'd0), "msip after reset");
      axi_read(OFS_CMP_LO, rd, RSP_OKAY);
      check_eq(rd, expect_rdata(OFS_CMP_LO, msip_sh, cmp_sh, 64'd0), "mtimecmp lo after reset");
      axi_read(OFS_CMP_HI, rd, RSP_OKAY);
      check_eq(rd, expect_rdata(OFS_CMP_HI, msip_sh, cmp_sh, 64'd0), "mtimecmp hi after reset");
      axi_read(OFS_TIME_HI, rd, RSP_OKAY);
      check_eq(rd, expect_rdata(OFS_TIME_HI, msip_sh, cmp_sh, 64'd0), "mtime hi after reset");

      // 2. Byte lane writes against the shadow copy
      for (int i = 0; i < 40; i++)
      begin
         rnd  = $random(seed);
         addr = (rnd[1:0] == 2'd0) ? OFS_MSIP : (rnd[1] ? OFS_CMP_HI : OFS_CMP_LO);
         data = $random(seed);
         axi_write(addr, data, rnd[7:4], RSP_OKAY);
         if (addr == OFS_MSIP)
            msip_sh = merge_msip(msip_sh, data, rnd[7:4]);
         else if (addr == OFS_CMP_LO)
            cmp_sh[31:0] = merge_lanes(cmp_sh[31:0], data, rnd[7:4]);
         else
            cmp_sh[63:32] = merge_lanes(cmp_sh[63:32], data, rnd[7:4]);
         axi_read(addr, rd, RSP_OKAY);
         check_eq(rd, expect_rdata(addr, msip_sh, cmp_sh, 64'd0), "read-back after write");
      end
      for (int i = 0; i < 8; i++)
      begin
         do
         begin
            rnd = $random(seed);
         end
         while (offset_mapped(rnd[15:0]));
         addr = rnd[15:0];
         data = $random(seed);
         axi_write(addr, data, 4'hF, expect_resp(addr));
         axi_read(addr, rd, expect_resp(addr));
         check_eq(rd, expect_rdata(addr, msip_sh, cmp_sh, 64'd0), "unmapped read data");
      end
      axi_read(OFS_MSIP, rd, RSP_OKAY);
      check_eq(rd, msip_sh, "msip after unmapped writes");
      axi_read(OFS_CMP_LO, rd, RSP_OKAY);
      check_eq(rd, cmp_sh[31:0], "mtimecmp lo after unmapped writes");
      axi_read(OFS_CMP_HI, rd, RSP_OKAY);
      check_eq(rd, cmp_sh[63:32], "mtimecmp hi after unmapped writes");

      // 3. mtime counting, second round forces a carry into hi
      for (int r = 0; r < 2; r++)
      begin
         rnd  = $random(seed);
         w_hi = {1'b0, rnd[30:0]};
         w_lo = (r == 0) ? $random(seed) : 32'hFFFF_FFFF;
         axi_write(OFS_TIME_LO, 32'd0, 4'hF, RSP_OKAY);   // No carry while hi is loaded
         axi_write(OFS_TIME_HI, w_hi, 4'hF, RSP_OKAY);
         axi_write(OFS_TIME_LO, w_lo, 4'hF, RSP_OKAY);
         t_wr = last_hs;
         rnd  = $random(seed);
         repeat (2 + rnd[2:0]) @(negedge clk_in);
         axi_read(OFS_TIME_LO, rd, RSP_OKAY);
         check_eq(mtime_in_window({w_hi, w_lo}, 64'(last_hs - t_wr), rd, 1'b0), 1'b1,
                  "mtime lo outside count window");
         axi_read(OFS_TIME_HI, rd, RSP_OKAY);
         check_eq(mtime_in_window({w_hi, w_lo}, 64'(last_hs - t_wr), rd, 1'b1), 1'b1,
                  "mtime hi outside count window");
      end

      // 4. Timer and software interrupt rules
      axi_write(OFS_CMP_HI, 32'hFFFF_FFFF, 4'hF, RSP_OKAY);
      axi_write(OFS_TIME_LO, 32'd0, 4'hF, RSP_OKAY);
      t_wr = last_hs;
      axi_write(OFS_TIME_HI, 32'd0, 4'hF, RSP_OKAY);    // lo skips one count here
      axi_write(OFS_CMP_LO, 32'(TMR_GAP), 4'hF, RSP_OKAY);
      axi_write(OFS_CMP_HI, 32'd0, 4'hF, RSP_OKAY);
      cmp_sh = 64'(TMR_GAP);
      for (int i = 0; i < 2 * TMR_GAP; i++)
      begin
         check_eq(timer_irq, timer_pending(64'(cyc - t_wr - 1), cmp_sh), "timer_irq");
         @(negedge clk_in);
      end
      axi_write(OFS_CMP_HI, 32'hFFFF_FFFF, 4'hF, RSP_OKAY);
      check_eq(timer_irq, 1'b0, "timer_irq after mtimecmp hi set");
      axi_write(OFS_MSIP, 32'h1, 4'h1, RSP_OKAY);
      check_eq(sw_irq, 1'b1, "sw_irq after msip set");
      axi_write(OFS_MSIP, 32'h0, 4'h1, RSP_OKAY);
      check_eq(sw_irq, 1'b0, "sw_irq after msip clear");

      // 5. Halt and wake
      exp_halt = 1'b0;
      tmr_pend = 1'b0;                                // mtimecmp hi is all ones
      sw_pend  = 1'b0;
      step_halt(1'b1, 1'b0);                          // WFI, nothing pending
      step_halt(1'b0, 1'b0);
      step_halt(1'b0, 1'b1);                          // External wake
      step_halt(1'b0, 1'b0);
      step_halt(1'b1, 1'b0);
      step_halt(1'b0, 1'b0);
      sw_pend = 1'b1;
      wake_by_write(OFS_MSIP, 32'h1, 4'h1);           // Software wake
      step_halt(1'b1, 1'b0);                          // msip still set
      step_halt(1'b0, 1'b0);
      axi_write(OFS_MSIP, 32'h0, 4'h1, RSP_OKAY);
      sw_pend = 1'b0;
      step_halt(1'b1, 1'b0);
      step_halt(1'b0, 1'b0);
      tmr_pend = 1'b1;                                // mtime long past TMR_GAP
      wake_by_write(OFS_CMP_HI, 32'h0, 4'hF);         // Timer wake, mtime past lo
      step_halt(1'b1, 1'b1);
      step_halt(1'b0, 1'b0);
      axi_write(OFS_CMP_HI, 32'hFFFF_FFFF, 4'hF, RSP_OKAY);
      tmr_pend = 1'b0;
      step_halt(1'b0, 1'b0);

      // 6. Reload steering, checked on every rising edge
      for (int i = 0; i < 100; i++)
      begin
         @(negedge clk_in);
         rnd             = $random(seed);
         wb_reload       = rnd[0];
         wb_ic_reload    = rnd[1];
         exe_reload      = rnd[2];
         rnd             = $random(seed);
         wb_reload_addr  = {rnd[31:2], 2'b00};        // Word aligned targets
         rnd             = $random(seed);
         exe_reload_addr = {rnd[31:2], 2'b00};
      end
      @(negedge clk_in);
      wb_reload    = 1'b0;
      wb_ic_reload = 1'b0;
      exe_reload   = 1'b0;
      repeat (2) @(negedge clk_in);

      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

/* project.f */
+incdir+tests
common/core_ctrl_pkg.sv
clint/clint_axi_port.sv
clint/clint_timer.sv
rtl/pipe_control.sv
rtl/core_ctrl_top.sv
tests/tb_core_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the core control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_core_ctrl
out=$(./obj_dir/Vtb_core_ctrl)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
   exit 0
fi
exit 1
